// ==== hw/isa_pkg.sv ====
package isa_pkg;

   typedef logic [31:0] word_t;     // data, address and instruction word
   typedef logic [3:0]  reg_addr_t; // one of R0..R15

   localparam int CALL_TARGET_BITS = 27; // absolute target field of a call

   typedef enum logic [4:0] {
      ALU_ADD = 5'd0,
      ALU_ADC = 5'd1,
      ALU_SUB = 5'd2,
      ALU_SBC = 5'd3,
      ALU_AND = 5'd4,
      ALU_OR  = 5'd5,
      ALU_XOR = 5'd6,
      ALU_SHL = 5'd7,
      ALU_SHR = 5'd8,
      ALU_ROR = 5'd9,
      ALU_CMP = 5'd10, // flags only
      ALU_NOT = 5'd11
   } alu_op_t;

   typedef enum logic [2:0] {
      CLS_NOP  = 3'd0,
      CLS_LD   = 3'd1,
      CLS_ST   = 3'd2,
      CLS_MOV  = 3'd3,
      CLS_LDL0 = 3'd4, // zero-extended immediate
      CLS_LDL  = 3'd5, // low half only
      CLS_LDH  = 3'd6, // high half only
      CLS_OP   = 3'd7
   } inst_class_t;

   typedef enum logic [1:0] {COND_S, COND_C, COND_Z, COND_V} cond_sel_t;

   // immediate is {rb, alu_op, lo_bits}, call target is the low 27 bits
   typedef struct packed {
      cond_sel_t   cond_sel;    // [31:30]
      logic        cond_value;  // [29]
      logic        cond_always; // [28] clear means unconditional
      logic        call;        // [27]
      inst_class_t inst_class;  // [26:24]
      reg_addr_t   rd;          // [23:20]
      reg_addr_t   ra;          // [19:16]
      reg_addr_t   rb;          // [15:12]
      alu_op_t     alu_op;      // [11:7]
      logic [6:0]  lo_bits;
   } inst_t;

endpackage

// ==== hw/core_pkg.sv ====
package core_pkg;

   typedef enum logic [1:0] {
      PH_FETCH = 2'd0,
      PH_EXEC  = 2'd1,
      PH_MEM   = 2'd2,
      PH_WB    = 2'd3
   } phase_t;

   typedef struct packed {
      logic v;
      logic z;
      logic s;
      logic c;
   } flags_t;

   typedef logic [3:0] test_sel_t;
   typedef logic [2:0] clk_stat_t; // {parity, phase}

   // register roles
   localparam logic [3:0] PC_REG   = 4'd15;
   localparam logic [3:0] LINK_REG = 4'd14;
   localparam logic [3:0] SP_REG   = 4'd13;

   // test_out selector codes
   localparam test_sel_t TSEL_PC    = 4'h0;
   localparam test_sel_t TSEL_R14   = 4'h1;
   localparam test_sel_t TSEL_R13   = 4'h2;
   localparam test_sel_t TSEL_IC    = 4'h3;
   localparam test_sel_t TSEL_ALU   = 4'h4;
   localparam test_sel_t TSEL_RES   = 4'h5;
   localparam test_sel_t TSEL_WB    = 4'h6;
   localparam test_sel_t TSEL_IDX   = 4'h7;
   localparam test_sel_t TSEL_OPD   = 4'h8;
   localparam test_sel_t TSEL_OPA   = 4'h9;
   localparam test_sel_t TSEL_OPB   = 4'ha;
   localparam test_sel_t TSEL_FLAGS = 4'hb;
   localparam test_sel_t TSEL_PHASE = 4'hc;
   localparam test_sel_t TSEL_ADDR  = 4'hd;
   localparam test_sel_t TSEL_DOUT  = 4'he;

endpackage

// ==== hw/phase_sched.sv ====
`timescale 1ns/1ps

module phase_sched import core_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   output logic      phf,
   output logic      phe,
   output logic      phm,
   output logic      phw,
   output clk_stat_t clk_stat
);

   phase_t phase;
   phase_t phase_nxt;
   logic   parity; // flips once per instruction

   always_comb
   begin
      case (phase)
         PH_FETCH: phase_nxt = PH_EXEC;
         PH_EXEC:  phase_nxt = PH_MEM;
         PH_MEM:   phase_nxt = PH_WB;
         default:  phase_nxt = PH_FETCH;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         phase  <= PH_FETCH;
         parity <= 1'b0;
      end
      else
      begin
         phase <= phase_nxt;
         if (phase == PH_WB)
            parity <= ~parity;
      end
   end

   assign phf = (phase == PH_FETCH);
   assign phe = (phase == PH_EXEC);
   assign phm = (phase == PH_MEM);
   assign phw = (phase == PH_WB);

   assign clk_stat = {parity, phase};

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import isa_pkg::*, core_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      pc_inc, // end of execute
   input  logic      wen,
   input  logic      link,   // call: R14 gets the next PC
   input  reg_addr_t wa,
   input  word_t     din,
   input  reg_addr_t ra,
   input  reg_addr_t rb,
   input  reg_addr_t rd,
   output word_t     da,
   output word_t     db,
   output word_t     dd,
   input  test_sel_t rt,
   output word_t     dt,
   output word_t     pc,
   output word_t     r14,
   output word_t     r13
);

   word_t regs [16];
   word_t pc_next;

   assign pc_next = regs[PC_REG] + 32'd1;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 16; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (pc_inc)
            regs[PC_REG] <= pc_next;
         if (link)
            regs[LINK_REG] <= pc_next;
         // last assignment wins, so writeback beats the increment
         if (wen)
            regs[wa] <= din;
      end
   end

   assign da  = regs[ra];
   assign db  = regs[rb];
   assign dd  = regs[rd];
   assign dt  = regs[rt];
   assign pc  = regs[PC_REG];
   assign r14 = regs[LINK_REG];
   assign r13 = regs[SP_REG];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu import isa_pkg::*, core_pkg::*;
(
   input  alu_op_t op,
   input  flags_t  flags_in,
   input  word_t   ai,
   input  word_t   bi,
   input  word_t   di,
   output word_t   res,
   output flags_t  flags_out
);

   logic        sub_op;
   logic        cin;
   word_t       b_eff;
   logic [32:0] sum;
   logic        add_v;
   logic [4:0]  shamt;
   logic [32:0] shl_wide;
   logic [32:0] shr_wide;
   word_t       ror_val;
   word_t       val;
   logic        c_new;
   logic        v_new;
   logic        known;

   // one adder for add, sub and cmp; subtraction is a + ~b + 1
   assign sub_op = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CMP);
   assign cin    = (op == ALU_ADC || op == ALU_SBC) ? flags_in.c : sub_op;
   assign b_eff  = sub_op ? ~bi : bi;
   assign sum    = {1'b0, ai} + {1'b0, b_eff} + {32'd0, cin};
   assign add_v  = (ai[31] == b_eff[31]) && (sum[31] != ai[31]);

   assign shamt    = bi[4:0];
   assign shl_wide = {1'b0, ai} << shamt; // top bit is last bit out
   assign shr_wide = {ai, 1'b0} >> shamt; // bottom bit is last bit out
   assign ror_val  = (ai >> shamt) | (ai << (6'd32 - {1'b0, shamt}));

   always_comb
   begin
      val   = di;
      c_new = flags_in.c;
      v_new = flags_in.v;
      known = 1'b1;
      case (op)
         ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CMP:
         begin
            val   = sum[31:0];
            c_new = sum[32]; // no borrow for subtractions
            v_new = add_v;
         end
         ALU_AND: val = ai & bi;
         ALU_OR:  val = ai | bi;
         ALU_XOR: val = ai ^ bi;
         ALU_NOT: val = ~ai;
         ALU_SHL: {c_new, val} = shl_wide;
         ALU_SHR: {val, c_new} = shr_wide;
         ALU_ROR:
         begin
            val   = ror_val;
            c_new = ror_val[31];
         end
         default: known = 1'b0;
      endcase
   end

   assign res = (op == ALU_CMP) ? di : val;

   assign flags_out = known ? '{v: v_new, z: (val == '0), s: val[31], c: c_new} : flags_in;

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/1ps

module cpu import isa_pkg::*, core_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   output word_t     mbus_aout,
   input  word_t     mbus_din,
   output word_t     mbus_dout,
   output logic      mbus_wen,
   input  test_sel_t test_sel,
   output word_t     test_out,
   output word_t     test_reg,
   output clk_stat_t clk_stat
);

   inst_t       ic;      // instruction register
   flags_t      flags;
   flags_t      alu_flags;
   word_t       mr_data; // load data latch
   word_t       pc, r14, r13;
   word_t       opa, opb, opd;
   word_t       alu_res;
   word_t       inst_res;
   word_t       wb_data;
   reg_addr_t   wb_addr;
   logic [15:0] imm;
   logic        phf, phe, phm, phw;
   logic        is_call, is_ld, is_st, is_op;
   logic        inst_wb, inst_br;
   logic        flag_hit, ena;
   logic        wb_en, link_en, flag_en;

   phase_sched i_sched (
      .clk      (clk),
      .rst_n    (rst_n),
      .phf      (phf),
      .phe      (phe),
      .phm      (phm),
      .phw      (phw),
      .clk_stat (clk_stat)
   );

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ic <= '0;
      else if (phf)
         ic <= mbus_din;
   end

   // class bits belong to the target on a call
   assign is_call = ic.call;
   assign is_ld   = !is_call && (ic.inst_class == CLS_LD);
   assign is_st   = !is_call && (ic.inst_class == CLS_ST);
   assign is_op   = !is_call && (ic.inst_class == CLS_OP);
   assign inst_wb = is_call || !(ic.inst_class inside {CLS_NOP, CLS_ST});
   assign inst_br = is_call || (inst_wb && ic.rd == PC_REG);
   assign imm     = {ic.rb, ic.alu_op, ic.lo_bits};

   always_comb
   begin
      case (ic.cond_sel)
         COND_S:  flag_hit = (flags.s == ic.cond_value);
         COND_C:  flag_hit = (flags.c == ic.cond_value);
         COND_Z:  flag_hit = (flags.z == ic.cond_value);
         default: flag_hit = (flags.v == ic.cond_value);
      endcase
   end

   assign ena = !ic.cond_always || flag_hit;

   assign wb_en   = ena && inst_wb && phw;
   assign link_en = ena && is_call && phe;
   assign flag_en = ena && is_op && phw;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         flags <= '0;
      else if (flag_en)
         flags <= alu_flags;
   end

   alu i_alu (
      .op        (ic.alu_op),
      .flags_in  (flags),
      .ai        (opa),
      .bi        (opb),
      .di        (opd),
      .res       (alu_res),
      .flags_out (alu_flags)
   );

   always_comb
   begin
      case (ic.inst_class)
         CLS_LD:   inst_res = mr_data;
         CLS_MOV:  inst_res = opa;
         CLS_LDL0: inst_res = {16'd0, imm};
         CLS_LDL:  inst_res = {opd[31:16], imm};
         CLS_LDH:  inst_res = {imm, opd[15:0]};
         CLS_OP:   inst_res = alu_res;
         default:  inst_res = '0;
      endcase
   end

   assign wb_data = is_call ? {{(32 - CALL_TARGET_BITS){1'b0}}, ic[CALL_TARGET_BITS-1:0]}
                            : inst_res;
   assign wb_addr = is_call ? PC_REG : ic.rd;

   reg_file i_regs (
      .clk    (clk),
      .rst_n  (rst_n),
      .pc_inc (phe),
      .wen    (wb_en),
      .link   (link_en),
      .wa     (wb_addr),
      .din    (wb_data),
      .ra     (ic.ra),
      .rb     (ic.rb),
      .rd     (ic.rd),
      .da     (opa),
      .db     (opb),
      .dd     (opd),
      .rt     (test_sel),
      .dt     (test_reg),
      .pc     (pc),
      .r14    (r14),
      .r13    (r13)
   );

   always_ff @(posedge clk)
   begin
      if (phm && is_ld)
         mr_data <= mbus_din;
   end

   // ld reads [rd], st writes rd to [ra]
   always_comb
   begin
      if (phf)
         mbus_aout = pc;
      else if (phe)
         mbus_aout = is_ld ? opd : pc;
      else if (phm)
         mbus_aout = is_ld ? opd : (is_st ? opa : pc);
      else
         mbus_aout = (inst_br && ena) ? wb_data : pc; // show the jump target
   end

   assign mbus_dout = opd;
   assign mbus_wen  = ena && phm && is_st;

   always_comb
   begin
      case (test_sel)
         TSEL_PC:    test_out = pc;
         TSEL_R14:   test_out = r14;
         TSEL_R13:   test_out = r13;
         TSEL_IC:    test_out = ic;
         TSEL_ALU:   test_out = alu_res;
         TSEL_RES:   test_out = inst_res;
         TSEL_WB:    test_out = wb_data;
         TSEL_IDX:   test_out = {19'd0, ena, ic.rd, ic.ra, ic.rb};
         TSEL_OPD:   test_out = opd;
         TSEL_OPA:   test_out = opa;
         TSEL_OPB:   test_out = opb;
         TSEL_FLAGS: test_out = {3'd0, flags.v, 3'd0, flags.z, 3'd0, flags.s, 3'd0, flags.c,
                                 2'd0, ic.cond_sel, 3'd0, ic.cond_value,
                                 3'd0, ic.cond_always, 3'd0, ena};
         TSEL_PHASE: test_out = {20'd0, wb_en, link_en, flag_en, mbus_wen,
                                 phw, phm, phe, phf, 1'b0, clk_stat};
         TSEL_ADDR:  test_out = mbus_aout;
         TSEL_DOUT:  test_out = mbus_dout;
         default:    test_out = test_reg; // 0xf mirrors the register port
      endcase
   end

endmodule

// ==== verif/cpu_mem_model.sv ====
`timescale 1ns/1ps

module cpu_mem_model import isa_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  word_t addr,
   input  word_t din,
   input  logic  wen,
   output word_t dout,
   input  word_t image [64], // program image copied in during reset
   output word_t st_count,
   output word_t st_addr,
   output word_t st_data
);

   word_t mem [64];

   // word addressed, wraps every 64 words
   assign dout = mem[addr[5:0]];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         mem      <= image;
         st_count <= '0;
         st_addr  <= '0;
         st_data  <= '0;
      end
      else if (wen)
      begin
         mem[addr[5:0]] <= din;
         st_count       <= st_count + 32'd1; // store log
         st_addr        <= addr;
         st_data        <= din;
      end
   end

endmodule

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import isa_pkg::*, core_pkg::*;
();

   localparam word_t ST_ADDR   = 32'h30;
   localparam word_t CALL_ADDR = 32'd18;
   localparam word_t SUB_ADDR  = 32'd40;
   localparam word_t HALT_ADDR = 32'd20;

   logic      clk;
   logic      rst_n;
   test_sel_t test_sel;
   word_t     mbus_aout;
   word_t     mbus_din;
   word_t     mbus_dout;
   logic      mbus_wen;
   word_t     test_out;
   word_t     test_reg;
   clk_stat_t clk_stat;
   word_t     image [64];
   word_t     st_count;
   word_t     st_addr;
   word_t     st_data;

   integer      seed;
   word_t       c1, c2, c3, rnd, diff;
   logic [4:0]  sh;
   logic [32:0] wide;
   flags_t      exp_flags;
   flags_t      act_flags;
   int          errors;
   int          checks;
   logic        halted;
   string       chk_name [$];
   test_sel_t   chk_reg [$];
   word_t       chk_exp [$];

   cpu i_cpu (
      .clk       (clk),
      .rst_n     (rst_n),
      .mbus_aout (mbus_aout),
      .mbus_din  (mbus_din),
      .mbus_dout (mbus_dout),
      .mbus_wen  (mbus_wen),
      .test_sel  (test_sel),
      .test_out  (test_out),
      .test_reg  (test_reg),
      .clk_stat  (clk_stat)
   );

   cpu_mem_model i_mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .addr     (mbus_aout),
      .din      (mbus_dout),
      .wen      (mbus_wen),
      .dout     (mbus_din),
      .image    (image),
      .st_count (st_count),
      .st_addr  (st_addr),
      .st_data  (st_data)
   );

   always #10 clk = ~clk;

   function automatic word_t make_inst(inst_class_t cls, reg_addr_t rd, reg_addr_t ra,
                                       logic [15:0] low);
      inst_t i;
      i = '0;
      i.inst_class = cls;
      i.rd = rd;
      i.ra = ra;
      return {i[31:16], low};
   endfunction

   function automatic word_t make_op(alu_op_t op, reg_addr_t rd, reg_addr_t ra, reg_addr_t rb);
      return make_inst(CLS_OP, rd, ra, {rb, op, 7'd0});
   endfunction

   function automatic word_t make_call(word_t target);
      inst_t i;
      i = '0;
      i.call = 1'b1;
      return {i[31:CALL_TARGET_BITS], target[CALL_TARGET_BITS-1:0]};
   endfunction

   // guard an instruction with flag == value
   function automatic word_t make_cond(word_t w, cond_sel_t sel, logic value);
      inst_t i;
      i = w;
      i.cond_sel = sel;
      i.cond_value = value;
      i.cond_always = 1'b1;
      return i;
   endfunction

   task automatic check_word(string name, word_t exp, word_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flags(string name, flags_t exp, flags_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[ERROR] %s: expected vzsc %b, actual vzsc %b", name, exp, act);
      end
   endtask

   task automatic check_stat(string name, clk_stat_t exp, clk_stat_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_reset_state(string tag);
      check_word({tag, " wen"}, '0, {31'd0, mbus_wen});
      check_word({tag, " pc"}, '0, test_out); // test_sel still on the PC
      check_word({tag, " aout"}, '0, mbus_aout);
      check_stat({tag, " clk_stat"}, {1'b0, PH_FETCH}, clk_stat);
   endtask

   task automatic add_check(string name, test_sel_t r, word_t exp);
      chk_name.push_back(name);
      chk_reg.push_back(r);
      chk_exp.push_back(exp);
   endtask

   initial
   begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      test_sel = TSEL_PC;
      errors   = 0;
      checks   = 0;
      halted   = 1'b0;
      seed     = 32'ha7e2b813;
      c1  = $random(seed);
      c2  = $random(seed);
      c3  = $random(seed);
      rnd = $random(seed);
      sh  = rnd[4:0];

      // cmp r1, r2 as a - b, carry means no borrow
      wide = {1'b0, c1} - {1'b0, c2};
      diff = wide[31:0];
      exp_flags.c = !wide[32];
      exp_flags.z = (diff == '0);
      exp_flags.s = diff[31];
      exp_flags.v = (c1[31] != c2[31]) && (diff[31] != c1[31]);

      for (int a = 0; a < 64; a++)
         image[a] = 32'h0000_a500 | a; // nop tagged with its address
      image[0]  = make_inst(CLS_LDL0, 4'd1, 4'd0, c1[15:0]);
      image[1]  = make_inst(CLS_LDH, 4'd1, 4'd0, c1[31:16]);
      image[2]  = make_inst(CLS_LDL0, 4'd2, 4'd0, c2[15:0]);
      image[3]  = make_inst(CLS_LDH, 4'd2, 4'd0, c2[31:16]);
      image[4]  = make_inst(CLS_LDH, 4'd3, 4'd0, c3[31:16]);
      image[5]  = make_inst(CLS_LDL, 4'd3, 4'd0, c3[15:0]);
      image[6]  = make_inst(CLS_LDL0, 4'd4, 4'd0, {11'd0, sh});
      image[7]  = make_op(ALU_ADD, 4'd5, 4'd1, 4'd2);
      image[8]  = make_op(ALU_SUB, 4'd6, 4'd1, 4'd2);
      image[9]  = make_op(ALU_XOR, 4'd7, 4'd1, 4'd3);
      image[10] = make_op(ALU_SHL, 4'd8, 4'd3, 4'd4);
      image[11] = make_op(ALU_CMP, 4'd3, 4'd1, 4'd2); // r3 must survive
      image[12] = make_cond(make_inst(CLS_MOV, 4'd10, 4'd1, 16'd0), COND_C, !exp_flags.c);
      image[13] = make_cond(make_inst(CLS_MOV, 4'd11, 4'd1, 16'd0), COND_C, exp_flags.c);
      image[14] = make_inst(CLS_LDL0, 4'd12, 4'd0, ST_ADDR[15:0]);
      image[15] = make_inst(CLS_ST, 4'd5, 4'd12, 16'd0); // [r12] = r5
      image[16] = make_inst(CLS_LDL0, 4'd13, 4'd0, ST_ADDR[15:0]);
      image[17] = make_inst(CLS_LD, 4'd13, 4'd0, 16'd0); // r13 = [r13]
      image[18] = make_call(SUB_ADDR);
      image[19] = make_inst(CLS_LDL0, 4'd9, 4'd0, 16'h5a5a); // return path only
      image[20] = make_inst(CLS_LDL0, 4'd15, 4'd0, HALT_ADDR[15:0]); // jump to self
      image[40] = make_inst(CLS_LDL0, 4'd0, 4'd0, 16'h1234);
      image[41] = make_inst(CLS_MOV, 4'd15, 4'd14, 16'd0);

      add_check("ldl0 ldh r1", 4'd1, c1);
      add_check("ldl0 ldh r2", 4'd2, c2);
      add_check("ldh ldl r3 after cmp", 4'd3, c3);
      add_check("shift amount r4", 4'd4, {27'd0, sh});
      add_check("add r5", 4'd5, c1 + c2);
      add_check("sub r6", 4'd6, c1 - c2);
      add_check("xor r7", 4'd7, c1 ^ c3);
      add_check("shl r8", 4'd8, c3 << sh);
      add_check("false cond mov r10", 4'd10, '0);
      add_check("true cond mov r11", 4'd11, c1);
      add_check("store address r12", 4'd12, ST_ADDR);
      add_check("ld after st r13", 4'd13, c1 + c2);
      add_check("call link r14", 4'd14, CALL_ADDR + 32'd1);
      add_check("subroutine r0", 4'd0, 32'h1234);
      add_check("return path r9", 4'd9, 32'h5a5a);

      repeat (16) @(posedge clk);
      #2;
      check_reset_state("in reset");
      rst_n = 1'b1;
      #8;
      check_reset_state("after reset");

      for (int cyc = 0; cyc < 2000 && !halted; cyc++)
      begin
         @(posedge clk);
         #10;
         if (test_out == HALT_ADDR && clk_stat[1:0] == PH_FETCH)
            halted = 1'b1;
      end

      if (!halted)
      begin
         errors++;
         $display("timeout: the program never reached its halt loop at %0h", HALT_ADDR);
      end
      else
      begin
         check_stat("halt phase and parity", {1'b0, PH_FETCH}, clk_stat); // 22 instructions
         // one pass through the halt loop, parity flips at its writeback
         for (int p = 1; p <= 4; p++)
         begin
            @(posedge clk);
            #10;
            check_stat($sformatf("halt loop step %0d", p), {p == 4, 2'(p % 4)}, clk_stat);
         end
         @(posedge clk);
         #2;
         test_sel = TSEL_FLAGS;
         #8;
         act_flags = {test_out[28], test_out[24], test_out[20], test_out[16]};
         check_flags("cmp flags", exp_flags, act_flags);
         for (int k = 0; k < chk_name.size(); k++)
         begin
            @(posedge clk);
            #2;
            test_sel = chk_reg[k];
            #8;
            check_word(chk_name[k], chk_exp[k], test_reg);
         end
         check_word("store count", 32'd1, st_count);
         check_word("store address", ST_ADDR, st_addr);
         check_word("store data", c1 + c2, st_data);
      end

      $display("checks run %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== src.f ====
hw/isa_pkg.sv
hw/core_pkg.sv
hw/phase_sched.sv
hw/reg_file.sv
hw/alu.sv
hw/cpu.sv
verif/cpu_mem_model.sv
verif/tb_cpu.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing
TOP   = tb_cpu
FLIST = src.f
PASS  = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
